/* logic/axis_avst_settings.svh */
// stream bridge sizes
`ifndef AXIS_AVST_SETTINGS_SVH
`define AXIS_AVST_SETTINGS_SVH

// bytes per beat on both stream sides
`define AXIS_AVST_DATA_BYTES 4

// tid on axi side, channel on avalon side
`define AXIS_AVST_CHANNEL_WIDTH 4

// word address into the register block
`define AXIS_AVST_WB_ADDR_WIDTH 2

// register data path
`define AXIS_AVST_WB_DATA_WIDTH 32

`endif

/* logic/axis_avst_pkg.sv */
// stream bridge types
`default_nettype none

`include "axis_avst_settings.svh"

package axis_avst_pkg;

    // tkeep / tstrb, one bit per byte
    typedef logic [`AXIS_AVST_DATA_BYTES-1:0] byte_mask_t;

    // avalon empty, enough bits for data bytes minus one
    typedef logic [$clog2(`AXIS_AVST_DATA_BYTES)-1:0] empty_t;

    typedef logic [`AXIS_AVST_CHANNEL_WIDTH-1:0] channel_t; // tid and channel

    typedef logic [31:0] count_t; // statistics counter

    // register map, word addresses
    typedef enum logic [`AXIS_AVST_WB_ADDR_WIDTH-1:0] {
        CTRL         = 2'd0, // bit 0 enable, bit 1 clear (write one)
        PKT_COUNT    = 2'd1,
        BYTE_COUNT   = 2'd2,
        LAST_CHANNEL = 2'd3
    } reg_addr_t;

endpackage

`default_nettype wire

/* logic/axis_to_avst.sv */
// axi4-stream to avalon-st bridge
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module axis_to_avst (
    input  logic                                  aclk,
    input  logic                                  areset_n,
    input  logic                                  enable,
    input  logic                                  rx_tvalid,
    output logic                                  rx_tready,
    input  logic [8*`AXIS_AVST_DATA_BYTES-1:0]    rx_tdata,
    input  axis_avst_pkg::byte_mask_t             rx_tkeep,
    input  axis_avst_pkg::byte_mask_t             rx_tstrb,
    input  logic                                  rx_tlast,
    input  axis_avst_pkg::channel_t               rx_tid,
    input  logic                                  tx_ready,
    output logic                                  tx_valid,
    output logic [8*`AXIS_AVST_DATA_BYTES-1:0]    tx_data,
    output axis_avst_pkg::channel_t               tx_channel,
    output logic                                  tx_startofpacket,
    output logic                                  tx_endofpacket,
    output axis_avst_pkg::empty_t                 tx_empty
);

    logic rx_fire;    // beat taken from axi side
    logic first_beat; // next accepted beat opens a packet

    // bytes missing from a low-aligned beat
    function automatic axis_avst_pkg::empty_t mask_to_empty(
        input axis_avst_pkg::byte_mask_t mask
    );
        int kept;
        kept = 0;
        for (int i = 0; i < `AXIS_AVST_DATA_BYTES; i++) begin
            if (mask[i]) kept++;
        end
        return axis_avst_pkg::empty_t'(`AXIS_AVST_DATA_BYTES - kept);
    endfunction

    assign rx_tready = tx_ready & enable; // straight through with no buffering
    assign rx_fire   = rx_tvalid & rx_tready;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_valid         <= 1'b0;
            tx_startofpacket <= 1'b1;
            first_beat       <= 1'b1;
        end else if (tx_ready) begin
            tx_valid         <= rx_tvalid & enable; // bubble while disabled
            tx_startofpacket <= first_beat;         // from previous accepted tlast
            if (rx_fire) first_beat <= rx_tlast;
        end
    end

    // payload meaningful only with tx_valid
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            tx_data        <= rx_tdata;
            tx_channel     <= rx_tid;
            tx_endofpacket <= rx_tlast;
            tx_empty       <= rx_tlast ? mask_to_empty(rx_tkeep & rx_tstrb) : '0;
        end
    end

    // held beat closes a packet exactly when the next accepted beat opens one
    a_sop_follows_eop: assert property (@(posedge aclk) disable iff (!areset_n)
        tx_valid |-> first_beat == tx_endofpacket);

    // only the closing beat may be partial
    a_full_mid_beat: assert property (@(posedge aclk) disable iff (!areset_n)
        rx_tvalid && !rx_tlast |-> (rx_tkeep & rx_tstrb) == '1);

endmodule

`default_nettype wire

/* logic/avst_packet_monitor.sv */
// avalon-st traffic statistics
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module avst_packet_monitor (
    input  logic                     aclk,
    input  logic                     areset_n,
    input  logic                     clear_counters, // one-cycle pulse from regs
    input  logic                     tx_valid,
    input  logic                     tx_ready,
    input  axis_avst_pkg::channel_t  tx_channel,
    input  logic                     tx_endofpacket,
    input  axis_avst_pkg::empty_t    tx_empty,
    output axis_avst_pkg::count_t    pkt_count,
    output axis_avst_pkg::count_t    byte_count,
    output axis_avst_pkg::channel_t  last_channel
);

    logic                  beat_fire;  // beat taken by the sink
    axis_avst_pkg::count_t beat_bytes; // bytes carried by this beat

    assign beat_fire = tx_valid & tx_ready;

    // full beat unless it closes a packet
    always_comb begin
        if (tx_endofpacket) begin
            beat_bytes = axis_avst_pkg::count_t'(`AXIS_AVST_DATA_BYTES)
                       - axis_avst_pkg::count_t'(tx_empty);
        end else begin
            beat_bytes = axis_avst_pkg::count_t'(`AXIS_AVST_DATA_BYTES);
        end
    end

    // counters, clear wins over counting
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else if (clear_counters) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else if (beat_fire) begin
            byte_count <= byte_count + beat_bytes;
            if (tx_endofpacket) pkt_count <= pkt_count + 1'b1; // one per packet
        end
    end

    // channel of the most recent accepted beat, not touched by clear
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            last_channel <= '0;
        end else if (beat_fire) begin
            last_channel <= tx_channel;
        end
    end

    // clear comes from a single write, never a level
    a_clear_is_pulse: assert property (@(posedge aclk) disable iff (!areset_n)
        clear_counters |=> !clear_counters);

endmodule

`default_nettype wire

/* logic/wb_stream_regs.sv */
// wishbone control and statistics registers
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module wb_stream_regs (
    input  logic                                aclk,
    input  logic                                areset_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  axis_avst_pkg::reg_addr_t            wb_adr,
    input  logic [`AXIS_AVST_WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [`AXIS_AVST_WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                                wb_ack,
    input  axis_avst_pkg::count_t               pkt_count,
    input  axis_avst_pkg::count_t               byte_count,
    input  axis_avst_pkg::channel_t             last_channel,
    output logic                                enable,
    output logic                                clear_counters
);

    logic                                wb_req;  // new cycle not yet acked
    logic                                wb_wr;   // write strobe at the ack edge
    logic [`AXIS_AVST_WB_DATA_WIDTH-1:0] rd_data; // read mux out

    assign wb_req = wb_cyc & wb_stb & ~wb_ack;
    assign wb_wr  = wb_req & wb_we;

    // read mux, narrow fields zero-extended
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            axis_avst_pkg::CTRL:       rd_data[0] = enable; // clear bit reads 0
            axis_avst_pkg::PKT_COUNT:  rd_data = pkt_count;
            axis_avst_pkg::BYTE_COUNT: rd_data = byte_count;
            axis_avst_pkg::LAST_CHANNEL: begin
                rd_data[`AXIS_AVST_CHANNEL_WIDTH-1:0] = last_channel;
            end
            default:                   rd_data = '0;
        endcase
    end

    // single-cycle ack
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // ctrl register and clear pulse
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            enable         <= 1'b0; // bridge stalled until software enables
            clear_counters <= 1'b0;
        end else begin
            clear_counters <= 1'b0; // default low, one cycle only
            if (wb_wr && wb_adr == axis_avst_pkg::CTRL) begin
                enable         <= wb_dat_w[0];
                clear_counters <= wb_dat_w[1];
            end
        end
    end

    // read data sampled with the ack
    always_ff @(posedge aclk) begin
        if (wb_req) wb_dat_r <= rd_data;
    end

    // master keeps the strobe up until it sees ack
    a_ack_in_cycle: assert property (@(posedge aclk) disable iff (!areset_n)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

/* logic/axis_avst_top.sv */
// axi4-stream to avalon-st bridge top
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module axis_avst_top (
    input  logic                                  aclk,
    input  logic                                  areset_n,
    // axi4-stream rx
    input  logic                                  rx_tvalid,
    output logic                                  rx_tready,
    input  logic [8*`AXIS_AVST_DATA_BYTES-1:0]    rx_tdata,
    input  axis_avst_pkg::byte_mask_t             rx_tkeep,
    input  axis_avst_pkg::byte_mask_t             rx_tstrb,
    input  logic                                  rx_tlast,
    input  axis_avst_pkg::channel_t               rx_tid,
    // avalon-st tx
    input  logic                                  tx_ready,
    output logic                                  tx_valid,
    output logic [8*`AXIS_AVST_DATA_BYTES-1:0]    tx_data,
    output axis_avst_pkg::channel_t               tx_channel,
    output logic                                  tx_startofpacket,
    output logic                                  tx_endofpacket,
    output axis_avst_pkg::empty_t                 tx_empty,
    // wishbone classic
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [`AXIS_AVST_WB_ADDR_WIDTH-1:0]   wb_adr,
    input  logic [`AXIS_AVST_WB_DATA_WIDTH-1:0]   wb_dat_w,
    output logic [`AXIS_AVST_WB_DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                  wb_ack
);

    logic                    enable;         // ctrl bit 0
    logic                    clear_counters; // ctrl bit 1 pulse
    axis_avst_pkg::count_t   pkt_count;
    axis_avst_pkg::count_t   byte_count;
    axis_avst_pkg::channel_t last_channel;

    axis_to_avst u_bridge (
        .aclk, .areset_n, .enable,
        .rx_tvalid, .rx_tready, .rx_tdata, .rx_tkeep, .rx_tstrb, .rx_tlast, .rx_tid,
        .tx_ready, .tx_valid, .tx_data, .tx_channel,
        .tx_startofpacket, .tx_endofpacket, .tx_empty
    );

    // watches the same tx port the sink sees
    avst_packet_monitor u_monitor (
        .aclk, .areset_n, .clear_counters,
        .tx_valid, .tx_ready, .tx_channel, .tx_endofpacket, .tx_empty,
        .pkt_count, .byte_count, .last_channel
    );

    wb_stream_regs u_regs (
        .aclk, .areset_n, .wb_cyc, .wb_stb, .wb_we,
        .wb_adr (axis_avst_pkg::reg_addr_t'(wb_adr)), // raw bus word to map enum
        .wb_dat_w, .wb_dat_r, .wb_ack,
        .pkt_count, .byte_count, .last_channel, .enable, .clear_counters
    );

endmodule

`default_nettype wire

/* verification/axis_avst_checker.sv */
// stream bridge scoreboard
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module axis_avst_checker (
    input  logic                               aclk,
    input  logic                               areset_n,
    input  logic                               rx_tvalid,
    input  logic                               rx_tready,
    input  logic [8*`AXIS_AVST_DATA_BYTES-1:0] rx_tdata,
    input  axis_avst_pkg::byte_mask_t          rx_tkeep,
    input  axis_avst_pkg::byte_mask_t          rx_tstrb,
    input  logic                               rx_tlast,
    input  axis_avst_pkg::channel_t            rx_tid,
    input  logic                               tx_ready,
    input  logic                               tx_valid,
    input  logic [8*`AXIS_AVST_DATA_BYTES-1:0] tx_data,
    input  axis_avst_pkg::channel_t            tx_channel,
    input  logic                               tx_startofpacket,
    input  logic                               tx_endofpacket,
    input  axis_avst_pkg::empty_t              tx_empty,
    input  logic                               idle_window // bridge disabled so nothing may move
);

    // one expected avalon beat
    typedef struct packed {
        logic [8*`AXIS_AVST_DATA_BYTES-1:0] data;
        axis_avst_pkg::channel_t            ch;
        logic                               sop;
        logic                               eop;
        axis_avst_pkg::empty_t              empty;
    } beat_t;

    beat_t                   model_q[$];       // accepted axi beats not yet seen on tx
    logic                    first_exp = 1'b1; // next axi beat opens a packet
    int                      err[1:5];         // error count per test
    int                      tx_beats = 0;     // accepted avalon beats
    axis_avst_pkg::count_t   exp_pkts = '0;
    axis_avst_pkg::count_t   exp_bytes = '0;
    axis_avst_pkg::channel_t exp_last_ch = '0;

    // bytes that are both kept and strobed
    function automatic int valid_bytes(input axis_avst_pkg::byte_mask_t keep, strb);
        int n;
        n = 0;
        for (int i = 0; i < `AXIS_AVST_DATA_BYTES; i++) n += keep[i] & strb[i];
        return n;
    endfunction

    function automatic int pending();
        return model_q.size();
    endfunction

    function automatic int total_errors();
        return err[1] + err[2] + err[3] + err[4] + err[5];
    endfunction

    task automatic compare_value(input int test, input string name,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, exp, act);
            err[test]++;
        end
    endtask

    task automatic report_problem(input int test, input string what);
        $display("Error at %0d ns: %s", $time, what);
        err[test]++;
    endtask

    initial for (int i = 1; i <= 5; i++) err[i] = 0;

    always @(posedge aclk) begin : scoreboard
        beat_t b;
        if (!areset_n) begin
            model_q.delete();
            first_exp = 1'b1;
        end else begin
            if (rx_tvalid && rx_tready) begin // push first so the pop below takes an older beat
                b.data  = rx_tdata;
                b.ch    = rx_tid;
                b.sop   = first_exp;
                b.eop   = rx_tlast;
                b.empty = rx_tlast ? axis_avst_pkg::empty_t'(`AXIS_AVST_DATA_BYTES
                                     - valid_bytes(rx_tkeep, rx_tstrb)) : '0;
                model_q.push_back(b);
                first_exp = rx_tlast;
            end
            if (tx_valid && tx_ready) begin
                tx_beats++;
                if (model_q.size() == 0) begin
                    report_problem(1, "avalon beat accepted with no axi beat pending");
                end else begin
                    b = model_q.pop_front();
                    compare_value(1, "tx_data", b.data, tx_data);
                    compare_value(1, "tx_channel", b.ch, tx_channel);
                    compare_value(2, "tx_startofpacket", b.sop, tx_startofpacket);
                    compare_value(2, "tx_endofpacket", b.eop, tx_endofpacket);
                    compare_value(3, "tx_empty", b.empty, tx_empty);
                    exp_bytes += b.eop ? `AXIS_AVST_DATA_BYTES - b.empty
                                       : `AXIS_AVST_DATA_BYTES;
                    if (b.eop) exp_pkts++;
                    exp_last_ch = b.ch;
                end
            end
            if (idle_window && rx_tready) report_problem(4, "rx_tready high while disabled");
            if (idle_window && tx_valid && tx_ready) begin
                report_problem(4, "avalon beat accepted while disabled");
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_axis_avst.sv */
// bridge testbench
`timescale 1ns/10ps
`default_nettype none

`include "axis_avst_settings.svh"

module tb_axis_avst;

    localparam int ACK_TIMEOUT   = 20;   // cycles
    localparam int DRAIN_TIMEOUT = 4000;

    logic                                  aclk;
    logic                                  areset_n;
    logic                                  rx_tvalid;
    logic                                  rx_tready;
    logic [8*`AXIS_AVST_DATA_BYTES-1:0]    rx_tdata;
    axis_avst_pkg::byte_mask_t             rx_tkeep;
    axis_avst_pkg::byte_mask_t             rx_tstrb;
    logic                                  rx_tlast;
    axis_avst_pkg::channel_t               rx_tid;
    logic                                  tx_ready;
    logic                                  tx_valid;
    logic [8*`AXIS_AVST_DATA_BYTES-1:0]    tx_data;
    axis_avst_pkg::channel_t               tx_channel;
    logic                                  tx_startofpacket;
    logic                                  tx_endofpacket;
    axis_avst_pkg::empty_t                 tx_empty;
    logic                                  wb_cyc;
    logic                                  wb_stb;
    logic                                  wb_we;
    logic [`AXIS_AVST_WB_ADDR_WIDTH-1:0]   wb_adr;
    logic [`AXIS_AVST_WB_DATA_WIDTH-1:0]   wb_dat_w;
    logic [`AXIS_AVST_WB_DATA_WIDTH-1:0]   wb_dat_r;
    logic                                  wb_ack;
    integer                                seed = 32'hb337_89b1;
    logic                                  gen_on;      // start new packets
    logic                                  idle_window; // checker expects silence while disabled
    int                                    beats_left;  // beats still to send in packet

    axis_avst_top u_dut (.*);
    axis_avst_checker u_checker (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // random source holding each axi beat until it is taken
    always @(posedge aclk) begin : stimulus
        int                        left;
        axis_avst_pkg::channel_t   tid;
        axis_avst_pkg::byte_mask_t keep;
        if (areset_n) begin
            tx_ready <= ($random(seed) & 3) != 0; // ready about 3 of 4 cycles
            if (!rx_tvalid || rx_tready) begin
                if (left == 0 && gen_on) begin
                    left = 1 + $unsigned($random(seed)) % 8;
                    tid  = $random(seed);
                end
                if (left != 0 && ($random(seed) & 1)) begin
                    keep = '1;
                    if (left == 1) begin // low-aligned mask of 1 to all bytes
                        keep = (1 << (1 + $unsigned($random(seed)) % `AXIS_AVST_DATA_BYTES)) - 1;
                    end
                    rx_tvalid <= 1'b1;
                    rx_tdata  <= $random(seed);
                    rx_tid    <= tid;
                    rx_tlast  <= (left == 1);
                    rx_tkeep  <= keep;
                    rx_tstrb  <= keep;
                    left--;
                end else begin
                    rx_tvalid <= 1'b0; // gap
                end
            end
            beats_left <= left;
        end
    end

    task automatic abort_run(input string why);
        $display("Error at %0d ns: %s", $time, why);
        $display("Errors found");
        $finish;
    endtask

    task automatic wb_transfer(input logic we, input axis_avst_pkg::reg_addr_t adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int   n;
        logic got;
        @(posedge aclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        got  = wb_ack;
        rdat = wb_dat_r; // valid while ack high
        @(posedge aclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!got) abort_run("wishbone access got no ack");
    endtask

    // stop new packets and wait until every accepted beat left the bridge
    task automatic drain();
        int n;
        gen_on <= 1'b0;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while ((beats_left != 0 || rx_tvalid || u_checker.pending() != 0)
                   && n < DRAIN_TIMEOUT);
        if (beats_left != 0 || rx_tvalid || u_checker.pending() != 0) begin
            abort_run("traffic did not drain");
        end
    endtask

    initial begin : main
        logic [31:0] rd;
        int          beats_before;
        areset_n    = 1'b0;
        rx_tvalid   = 1'b0;
        rx_tdata    = '0;
        rx_tkeep    = '0;
        rx_tstrb    = '0;
        rx_tlast    = 1'b0;
        rx_tid      = '0;
        tx_ready    = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        gen_on      = 1'b0;
        idle_window = 1'b0;
        beats_left  = 0;
        repeat (4) @(posedge aclk);
        areset_n <= 1'b1;

        // random traffic under back-pressure
        wb_transfer(1'b1, axis_avst_pkg::CTRL, 32'h1, rd);
        gen_on <= 1'b1;
        repeat (800) @(posedge aclk);
        drain();
        $display("test 1 data integrity: %0d beats, %0d errors",
                 u_checker.tx_beats, u_checker.err[1]);
        $display("test 2 framing: %0d errors", u_checker.err[2]);
        $display("test 3 empty: %0d errors", u_checker.err[3]);

        // disabled window then resume
        wb_transfer(1'b1, axis_avst_pkg::CTRL, 32'h0, rd);
        gen_on      <= 1'b1;
        idle_window <= 1'b1;
        repeat (60) @(posedge aclk);
        idle_window <= 1'b0;
        beats_before = u_checker.tx_beats;
        wb_transfer(1'b1, axis_avst_pkg::CTRL, 32'h1, rd);
        repeat (200) @(posedge aclk);
        drain();
        if (u_checker.tx_beats == beats_before) begin
            u_checker.report_problem(4, "no traffic after enable was set again");
        end
        $display("test 4 enable: %0d errors", u_checker.err[4]);

        // statistics against model totals then clear
        wb_transfer(1'b0, axis_avst_pkg::PKT_COUNT, 32'h0, rd);
        u_checker.compare_value(5, "PKT_COUNT", u_checker.exp_pkts, rd);
        wb_transfer(1'b0, axis_avst_pkg::BYTE_COUNT, 32'h0, rd);
        u_checker.compare_value(5, "BYTE_COUNT", u_checker.exp_bytes, rd);
        wb_transfer(1'b0, axis_avst_pkg::LAST_CHANNEL, 32'h0, rd);
        u_checker.compare_value(5, "LAST_CHANNEL", u_checker.exp_last_ch, rd);
        wb_transfer(1'b1, axis_avst_pkg::CTRL, 32'h3, rd); // keep enable and pulse clear
        wb_transfer(1'b0, axis_avst_pkg::PKT_COUNT, 32'h0, rd);
        u_checker.compare_value(5, "PKT_COUNT", 32'h0, rd);
        wb_transfer(1'b0, axis_avst_pkg::BYTE_COUNT, 32'h0, rd);
        u_checker.compare_value(5, "BYTE_COUNT", 32'h0, rd);
        $display("test 5 statistics: %0d errors", u_checker.err[5]);

        $display("5 tests, %0d errors", u_checker.total_errors());
        if (u_checker.total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axis_avst.f */
+incdir+logic
logic/axis_avst_pkg.sv
logic/axis_to_avst.sv
logic/avst_packet_monitor.sv
logic/wb_stream_regs.sv
logic/axis_avst_top.sv
verification/axis_avst_checker.sv
verification/tb_axis_avst.sv

/* Bender.yml */
package:
  name: axis_avst

sources:
  - include_dirs:
      - logic
    files:
      - logic/axis_avst_pkg.sv
      - logic/axis_to_avst.sv
      - logic/avst_packet_monitor.sv
      - logic/wb_stream_regs.sv
      - logic/axis_avst_top.sv
      - target: test
        files:
          - verification/axis_avst_checker.sv
          - verification/tb_axis_avst.sv
